/* design/bsBusPkg.sv */
`default_nettype none

package bsBusPkg;

    // ******************************************************************
    // Host bus geometry
    // ******************************************************************
    parameter int busDataW = 16;
    parameter int busAddrW = 12;

    // One bus cycle as seen by the register block
    typedef struct packed {
        logic                cs;
        logic                rd;
        logic                wrLo;    // byte 0 strobe
        logic                wrHi;    // byte 1 strobe
        logic [busAddrW-1:0] addr;
        logic [busDataW-1:0] data;
    } hostReqT;

    // ******************************************************************
    // Register map
    // ******************************************************************
    // Word addresses of the 32-bit registers
    // addr[1] picks the upper or lower 16-bit half
    typedef enum logic [busAddrW-1:0] {
        REG_VERSION = 12'h000,
        REG_CONTROL = 12'h004,
        REG_DAC_SEL = 12'h008,
        REG_OUT_SEL = 12'h00C
    } regAddrE;

endpackage

`default_nettype wire

/* design/bsRoutePkg.sv */
`default_nettype none

package bsRoutePkg;

    // Converter and sample widths
    parameter int sampleW = 18;
    parameter int adcW    = 14;
    parameter int dacW    = 14;

    // Sample stream, valid marks a new sample for one cycle
    typedef struct packed {
        logic signed [sampleW-1:0] data;
        logic                      valid;
    } sampleT;

    // Recovered symbol clock and bit of one channel
    typedef struct packed {
        logic symClk;
        logic symBit;
    } symbolT;

    // Monitor DAC source, unknown codes fall back to channel 0
    typedef enum logic [2:0] {
        DAC_SEL_CH0 = 3'd0,
        DAC_SEL_CH1 = 3'd1
    } dacSelE;

    // Front-panel source, unknown codes drive the pair low
    typedef enum logic [3:0] {
        OUT_SEL_CH0 = 4'd0,
        OUT_SEL_CH1 = 4'd2
    } outSelE;

    typedef struct packed {
        outSelE bsCoax;
        outSelE bsRs422;
        outSelE encCoax;
        outSelE fsCoax;
        outSelE fsRs422;
    } routeCfgT;

    typedef struct packed {
        dacSelE dac0;
        dacSelE dac1;
        dacSelE dac2;
    } dacCfgT;

endpackage

`default_nettype wire

/* design/hostRegs.sv */
`timescale 1ns/10ps
`default_nettype none

module hostRegs
    import bsBusPkg::*;
    import bsRoutePkg::*;
#(
    parameter int VERSION = 422
) (
    input  wire hostReqT             req,
    input  wire                      clk,
    input  wire                      rstN,
    output logic [busDataW-1:0]      readData,
    output logic [1:0]               coreEnable,
    output dacCfgT                   dacCfg,
    output routeCfgT                 routeCfg
);

    localparam int regW = 2 * busDataW;

    logic [busAddrW-1:0] wordAddr;
    logic [regW/8-1:0]   byteEn;
    logic [regW-1:0]     ctrlReg;
    logic [regW-1:0]     dacSelReg;
    logic [regW-1:0]     outSelReg;
    logic [regW-1:0]     readWord;

    // Bus data lands on whichever half addr[1] names
    function automatic logic [regW-1:0] mergeBytes(input logic [regW-1:0]     old,
                                                   input logic [regW/8-1:0]   be,
                                                   input logic [busDataW-1:0] data);
        logic [regW-1:0] result;
        result = old;
        for (int i = 0; i < regW / 8; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = data[8*(i % 2) +: 8];
            end
        end
        return result;
    endfunction

    assign wordAddr = {req.addr[busAddrW-1:2], 2'b00};

    // ******************************************************************
    // Write decode
    // ******************************************************************
    always_comb begin
        byteEn = '0;
        if (req.cs) begin
            if (req.addr[1]) begin
                byteEn = {req.wrHi, req.wrLo, 2'b00};
            end else begin
                byteEn = {2'b00, req.wrHi, req.wrLo};
            end
        end
    end

    // Version register is read only, so it has no case here
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlReg   <= '0;
            dacSelReg <= '0;
            outSelReg <= '0;
        end else if (|byteEn) begin
            case (wordAddr)
                REG_CONTROL: ctrlReg   <= mergeBytes(ctrlReg, byteEn, req.data);
                REG_DAC_SEL: dacSelReg <= mergeBytes(dacSelReg, byteEn, req.data);
                REG_OUT_SEL: outSelReg <= mergeBytes(outSelReg, byteEn, req.data);
                default: ;
            endcase
        end
    end

    // ******************************************************************
    // Configuration fields, one nibble per select
    // ******************************************************************
    assign coreEnable = ctrlReg[1:0];

    assign dacCfg = '{dac0: dacSelE'(dacSelReg[2:0]),
                      dac1: dacSelE'(dacSelReg[6:4]),
                      dac2: dacSelE'(dacSelReg[10:8])};

    assign routeCfg = '{bsCoax:  outSelE'(outSelReg[3:0]),
                        bsRs422: outSelE'(outSelReg[7:4]),
                        encCoax: outSelE'(outSelReg[11:8]),
                        fsCoax:  outSelE'(outSelReg[15:12]),
                        fsRs422: outSelE'(outSelReg[19:16])};

    // Read mux, unmapped words return zero
    always_comb begin
        case (wordAddr)
            REG_VERSION: readWord = regW'(VERSION);
            REG_CONTROL: readWord = ctrlReg;
            REG_DAC_SEL: readWord = dacSelReg;
            REG_OUT_SEL: readWord = outSelReg;
            default:     readWord = '0;
        endcase
    end

    // Held until the next read
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readData <= '0;
        end else if (req.cs && req.rd) begin
            readData <= req.addr[1] ? readWord[regW-1:busDataW] : readWord[busDataW-1:0];
        end
    end

endmodule

`default_nettype wire

/* design/adcCondition.sv */
`timescale 1ns/10ps
`default_nettype none

module adcCondition
    import bsRoutePkg::*;
(
    input  wire             clk,
    input  wire             rstN,
    input  wire [adcW-1:0]  adc0,
    input  wire [adcW-1:0]  adc1,
    output sampleT          rx0,
    output sampleT          rx1
);

    logic [adcW-1:0] adc0Reg;
    logic [adcW-1:0] adc1Reg;

    // Offset binary to two's complement, left justified in the sample
    function automatic logic signed [sampleW-1:0] toSample(input logic [adcW-1:0] raw);
        return {~raw[adcW-1], raw[adcW-2:0], {(sampleW - adcW){1'b0}}};
    endfunction

    // Pad reclock
    always_ff @(posedge clk) begin
        adc0Reg <= adc0;
        adc1Reg <= adc1;
    end

    // ADC runs at the system rate so every cycle carries a sample
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rx0 <= '0;
            rx1 <= '0;
        end else begin
            rx0 <= '{data: toSample(adc0Reg), valid: 1'b1};
            rx1 <= '{data: toSample(adc1Reg), valid: 1'b1};
        end
    end

endmodule

`default_nettype wire

/* design/dacDriver.sv */
`timescale 1ns/10ps
`default_nettype none

module dacDriver
    import bsRoutePkg::*;
(
    input  wire               clk,
    input  wire               rstN,
    input  wire dacSelE       sel,
    input  wire sampleT       ch0,
    input  wire sampleT       ch1,
    output logic [dacW-1:0]   dacData
);

    localparam logic [dacW-1:0] midScale = 1 << (dacW - 1);

    logic [sampleW-1:0] selData;
    logic               selValid;

    // Stage 1 source select
    always_ff @(posedge clk) begin
        case (sel)
            DAC_SEL_CH1: selData <= ch1.data;
            default:     selData <= ch0.data;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            selValid <= 1'b0;
        end else begin
            case (sel)
                DAC_SEL_CH1: selValid <= ch1.valid;
                default:     selValid <= ch0.valid;
            endcase
        end
    end

    // Stage 2 holds the last valid sample, flipping the sign bit for the DAC
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dacData <= midScale;
        end else if (selValid) begin
            dacData <= {~selData[sampleW-1], selData[sampleW-2 -: dacW-1]};
        end
    end

endmodule

`default_nettype wire

/* design/outputRouter.sv */
`timescale 1ns/10ps
`default_nettype none

module outputRouter
    import bsRoutePkg::*;
(
    input  wire            clk,
    input  wire            rstN,
    input  wire routeCfgT  cfg,
    input  wire symbolT    ch0Sym,
    input  wire symbolT    ch1Sym,
    input  wire            ch0Lock,
    input  wire            ch1Lock,
    output symbolT         bsCoax,
    output symbolT         bsRs422,
    output symbolT         encCoax,
    output symbolT         fsCoax,
    output symbolT         fsRs422,
    output logic           ch0LockN,
    output logic           ch1LockN
);

    // Clock/data pair for one front-panel connector
    function automatic symbolT routeSym(input outSelE sel,
                                        input symbolT sym0,
                                        input symbolT sym1);
        symbolT result;
        case (sel)
            OUT_SEL_CH0: result = sym0;
            OUT_SEL_CH1: result = sym1;
            default:     result = '0;
        endcase
        return result;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bsCoax   <= '0;
            bsRs422  <= '0;
            encCoax  <= '0;
            fsCoax   <= '0;
            fsRs422  <= '0;
            ch0LockN <= 1'b1;
            ch1LockN <= 1'b1;
        end else begin
            bsCoax   <= routeSym(cfg.bsCoax, ch0Sym, ch1Sym);
            bsRs422  <= routeSym(cfg.bsRs422, ch0Sym, ch1Sym);
            encCoax  <= routeSym(cfg.encCoax, ch0Sym, ch1Sym);
            fsCoax   <= routeSym(cfg.fsCoax, ch0Sym, ch1Sym);
            fsRs422  <= routeSym(cfg.fsRs422, ch0Sym, ch1Sym);
            // LEDs light when low
            ch0LockN <= ~ch0Lock;
            ch1LockN <= ~ch1Lock;
        end
    end

endmodule

`default_nettype wire

/* design/bitsyncIoTop.sv */
`timescale 1ns/10ps
`default_nettype none

module bitsyncIoTop
    import bsBusPkg::*;
    import bsRoutePkg::*;
#(
    parameter int VERSION = 422
) (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire hostReqT          hostReq,
    output logic [busDataW-1:0]   readData,
    output logic [1:0]            coreEnable,
    input  wire [adcW-1:0]        adc0,
    input  wire [adcW-1:0]        adc1,
    output sampleT                rx0,
    output sampleT                rx1,
    input  wire sampleT           ch0Sample,
    input  wire sampleT           ch1Sample,
    input  wire symbolT           ch0Sym,
    input  wire symbolT           ch1Sym,
    input  wire                   ch0Lock,
    input  wire                   ch1Lock,
    output logic [dacW-1:0]       dac0Data,
    output logic [dacW-1:0]       dac1Data,
    output logic [dacW-1:0]       dac2Data,
    output symbolT                bsCoax,
    output symbolT                bsRs422,
    output symbolT                encCoax,
    output symbolT                fsCoax,
    output symbolT                fsRs422,
    output logic                  ch0LockN,
    output logic                  ch1LockN
);

    dacCfgT   dacCfg;
    routeCfgT routeCfg;

    // ******************************************************************
    // Host registers
    // ******************************************************************
    hostRegs #(.VERSION(VERSION)) i_hostRegs (
        .clk(clk), .rstN(rstN),
        .req(hostReq),
        .readData(readData),
        .coreEnable(coreEnable),
        .dacCfg(dacCfg),
        .routeCfg(routeCfg)
    );

    // ADC words out to the external core
    adcCondition i_adcCondition (
        .clk(clk), .rstN(rstN),
        .adc0(adc0), .adc1(adc1),
        .rx0(rx0), .rx1(rx1)
    );

    // ******************************************************************
    // Monitor DACs
    // ******************************************************************
    dacDriver i_dac0 (
        .clk(clk), .rstN(rstN), .sel(dacCfg.dac0),
        .ch0(ch0Sample), .ch1(ch1Sample), .dacData(dac0Data)
    );

    dacDriver i_dac1 (
        .clk(clk), .rstN(rstN), .sel(dacCfg.dac1),
        .ch0(ch0Sample), .ch1(ch1Sample), .dacData(dac1Data)
    );

    dacDriver i_dac2 (
        .clk(clk), .rstN(rstN), .sel(dacCfg.dac2),
        .ch0(ch0Sample), .ch1(ch1Sample), .dacData(dac2Data)
    );

    // Front panel and lock LEDs
    outputRouter i_outputRouter (
        .clk(clk), .rstN(rstN),
        .cfg(routeCfg),
        .ch0Sym(ch0Sym), .ch1Sym(ch1Sym),
        .ch0Lock(ch0Lock), .ch1Lock(ch1Lock),
        .bsCoax(bsCoax), .bsRs422(bsRs422), .encCoax(encCoax),
        .fsCoax(fsCoax), .fsRs422(fsRs422),
        .ch0LockN(ch0LockN), .ch1LockN(ch1LockN)
    );

endmodule

`default_nettype wire

/* verif/bitsyncIoTb_props.sv */
`timescale 1ns/10ps
`default_nettype none

module bitsyncIoProps
    import bsBusPkg::*;
    import bsRoutePkg::*;
(
    input  wire                  clk,
    input  wire                  rstN,
    input  wire hostReqT         hostReq,
    input  wire [busDataW-1:0]   readData,
    input  wire dacCfgT          dacCfg,
    input  wire sampleT          ch0Sample,
    input  wire sampleT          ch1Sample,
    input  wire [dacW-1:0]       dac0Data,
    input  wire [dacW-1:0]       dac1Data,
    input  wire [dacW-1:0]       dac2Data
);

    int         failCount = 0;
    logic [2:0] pickedValid;

    // Valid of the channel a DAC select points at
    function automatic logic pickValid(input dacSelE sel, input sampleT s0, input sampleT s1);
        return (sel == DAC_SEL_CH1) ? s1.valid : s0.valid;
    endfunction

    assign pickedValid = {pickValid(dacCfg.dac2, ch0Sample, ch1Sample),
                          pickValid(dacCfg.dac1, ch0Sample, ch1Sample),
                          pickValid(dacCfg.dac0, ch0Sample, ch1Sample)};

    // **********************************************************************
    // DAC outputs move only on a selected valid two edges back
    // **********************************************************************
    dac0Moves: assert property (@(posedge clk) disable iff (!rstN)
        (dac0Data != $past(dac0Data)) |-> $past(pickedValid[0], 2))
    else begin
        failCount++;
        $error("dac0Data changed without a selected valid sample");
    end

    dac1Moves: assert property (@(posedge clk) disable iff (!rstN)
        (dac1Data != $past(dac1Data)) |-> $past(pickedValid[1], 2))
    else begin
        failCount++;
        $error("dac1Data changed without a selected valid sample");
    end

    dac2Moves: assert property (@(posedge clk) disable iff (!rstN)
        (dac2Data != $past(dac2Data)) |-> $past(pickedValid[2], 2))
    else begin
        failCount++;
        $error("dac2Data changed without a selected valid sample");
    end

    // Read data straight out of reset
    readZeroAfterReset: assert property (@(posedge clk) $rose(rstN) |-> readData == '0)
    else begin
        failCount++;
        $error("readData not zero in the cycle after reset");
    end

    // Read data only moves on a read strobe
    readHeld: assert property (@(posedge clk) disable iff (!rstN)
        !(hostReq.cs && hostReq.rd) |=> readData == $past(readData))
    else begin
        failCount++;
        $error("readData changed without a read");
    end

endmodule

bind bitsyncIoTop bitsyncIoProps i_props (
    .clk(clk), .rstN(rstN),
    .hostReq(hostReq), .readData(readData),
    .dacCfg(dacCfg),
    .ch0Sample(ch0Sample), .ch1Sample(ch1Sample),
    .dac0Data(dac0Data), .dac1Data(dac1Data), .dac2Data(dac2Data)
);

`default_nettype wire

/* verif/bitsyncIoTb.sv */
`timescale 1ns/10ps
`default_nettype none

module bitsyncIoTb
    import bsBusPkg::*;
    import bsRoutePkg::*;
();

    localparam int versionId = 422;

    logic                clk;
    logic                rstN;
    hostReqT             hostReq;
    logic [busDataW-1:0] readData;
    logic [1:0]          coreEnable;
    logic [adcW-1:0]     adc0;
    logic [adcW-1:0]     adc1;
    sampleT              rx0;
    sampleT              rx1;
    sampleT              ch0Sample;
    sampleT              ch1Sample;
    symbolT              ch0Sym;
    symbolT              ch1Sym;
    logic                ch0Lock;
    logic                ch1Lock;
    logic [dacW-1:0]     dac0Data;
    logic [dacW-1:0]     dac1Data;
    logic [dacW-1:0]     dac2Data;
    symbolT              bsCoax;
    symbolT              bsRs422;
    symbolT              encCoax;
    symbolT              fsCoax;
    symbolT              fsRs422;
    logic                ch0LockN;
    logic                ch1LockN;

    // Front-panel pairs in the same order as the select nibbles
    symbolT panel [5];
    string  panelName [5] = '{"bsCoax", "bsRs422", "encCoax", "fsCoax", "fsRs422"};
    int     errors;
    int     testCount;

    bitsyncIoTop i_dut (.*);

    assign panel[0] = bsCoax;
    assign panel[1] = bsRs422;
    assign panel[2] = encCoax;
    assign panel[3] = fsCoax;
    assign panel[4] = fsRs422;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // **********************************************************************
    // Helpers
    // **********************************************************************
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic reportFail(input string msg);
        $display("Fail at %0t: %s", $realtime, msg);
        errors++;
    endtask

    task automatic closeTest(input string name, input int errorsAtStart);
        testCount++;
        if (errors == errorsAtStart) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - errorsAtStart);
        end
    endtask

    task automatic busWrite(input logic [busAddrW-1:0] addr, input logic [busDataW-1:0] data,
                            input logic lo, input logic hi);
        hostReq = '{cs: 1'b1, rd: 1'b0, wrLo: lo, wrHi: hi, addr: addr, data: data};
        tick();
        hostReq = '0;
    endtask

    task automatic busRead(input logic [busAddrW-1:0] addr, output logic [busDataW-1:0] data);
        hostReq = '{cs: 1'b1, rd: 1'b1, wrLo: 1'b0, wrHi: 1'b0, addr: addr, data: '0};
        tick();
        data = readData;
        hostReq = '0;
    endtask

    task automatic readCheck(input logic [busAddrW-1:0] addr, input logic [busDataW-1:0] expected);
        logic [busDataW-1:0] got;
        busRead(addr, got);
        if (got !== expected) begin
            reportFail($sformatf("addr %h read %h, expected %h", addr, got, expected));
        end
    endtask

    // DAC code is sample bits 17 down to 4 with bit 17 flipped
    function automatic logic [dacW-1:0] dacCode(input logic [sampleW-1:0] s);
        return {~s[sampleW-1], s[sampleW-2:sampleW-dacW]};
    endfunction

    function automatic sampleT adcSample(input logic [adcW-1:0] a);
        sampleT s;
        s.data  = {~a[adcW-1], a[adcW-2:0], 4'b0000};
        s.valid = 1'b1;
        return s;
    endfunction

    function automatic symbolT expectPair(input logic [3:0] code, input symbolT s0,
                                          input symbolT s1);
        if (code == 4'd0) return s0;
        if (code == 4'd2) return s1;
        return '0;
    endfunction

    // **********************************************************************
    // Tests
    // **********************************************************************
    task automatic resetTest();
        int start;
        start = errors;
        if (readData !== '0) reportFail($sformatf("readData is %h after reset", readData));
        for (int i = 0; i < 5; i++) begin
            if (panel[i] !== '0) begin
                reportFail($sformatf("%s is %b after reset", panelName[i], panel[i]));
            end
        end
        if ({ch0LockN, ch1LockN} !== 2'b11) reportFail("lock outputs not high after reset");
        if (dac0Data !== 14'h2000 || dac1Data !== 14'h2000 || dac2Data !== 14'h2000) begin
            reportFail($sformatf("DACs at %h %h %h, expected 2000", dac0Data, dac1Data, dac2Data));
        end
        if (coreEnable !== 2'b00) begin
            reportFail($sformatf("coreEnable is %b after reset", coreEnable));
        end
        closeTest("reset", start);
    endtask

    task automatic regTest();
        int start;
        logic [busDataW-1:0] value;
        logic [busDataW-1:0] expected;
        logic [busAddrW-1:0] halves [4];
        start = errors;
        halves = '{12'h008, 12'h00A, 12'h00C, 12'h00E};
        readCheck(REG_VERSION, versionId);
        busWrite(REG_VERSION, 16'($urandom), 1'b1, 1'b1);
        readCheck(REG_VERSION, versionId);
        foreach (halves[i]) begin
            value = 16'($urandom);
            busWrite(halves[i], value, 1'b1, 1'b1);
            readCheck(halves[i], value);
            expected = value;
            // Single byte strobes leave the other byte alone
            value = 16'($urandom);
            expected[15:8] = value[15:8];
            busWrite(halves[i], value, 1'b0, 1'b1);
            readCheck(halves[i], expected);
            value = 16'($urandom);
            expected[7:0] = value[7:0];
            busWrite(halves[i], value, 1'b1, 1'b0);
            readCheck(halves[i], expected);
        end
        busWrite(12'h010, 16'($urandom), 1'b1, 1'b1);
        readCheck(12'h010, '0);
        readCheck(12'h7F2, '0);
        closeTest("registers", start);
    endtask

    task automatic routeTest();
        int          start;
        int          other;
        logic [3:0]  code [5];
        logic [19:0] cfg;
        symbolT      expected;
        start = errors;
        for (int i = 0; i < 5; i++) begin
            other = (i + 1) % 5;
            foreach (code[j]) code[j] = 4'd0;
            code[i] = 4'd2;
            code[other] = 4'(3 + $urandom % 13);
            for (int j = 0; j < 5; j++) cfg[4*j +: 4] = code[j];
            busWrite(REG_OUT_SEL, cfg[15:0], 1'b1, 1'b1);
            busWrite(12'h00E, {12'h000, cfg[19:16]}, 1'b1, 1'b1);
            for (int n = 0; n < 4; n++) begin
                ch0Sym = 2'($urandom);
                ch1Sym = 2'($urandom);
                tick();
                for (int j = 0; j < 5; j++) begin
                    expected = expectPair(code[j], ch0Sym, ch1Sym);
                    if (panel[j] !== expected) begin
                        reportFail($sformatf("%s is %b with code %0d, expected %b",
                                             panelName[j], panel[j], code[j], expected));
                    end
                end
            end
        end
        // LED drive is the inverse of lock
        for (int n = 1; n < 3; n++) begin
            {ch0Lock, ch1Lock} = 2'(n);
            tick();
            if ({ch0LockN, ch1LockN} !== ~2'(n)) begin
                reportFail($sformatf("lock outputs %b for locks %b", {ch0LockN, ch1LockN}, 2'(n)));
            end
        end
        closeTest("routing", start);
    endtask

    task automatic dacTest();
        int                 start;
        int                 count;
        logic [sampleW-1:0] d0;
        logic [sampleW-1:0] d1;
        logic [dacW-1:0]    held [3];
        start = errors;
        // dac0 on channel 0, dac1 on channel 1, dac2 on the undefined code 5
        busWrite(REG_DAC_SEL, 16'h0510, 1'b1, 1'b1);
        d0 = sampleW'($urandom);
        d1 = sampleW'($urandom);
        if (dacCode(d1) == dac1Data) d1 = d1 ^ 18'h10;
        ch0Sample = '{data: d0, valid: 1'b1};
        ch1Sample = '{data: d1, valid: 1'b1};
        count = 0;
        while (dac1Data !== dacCode(d1) && count < 10) begin
            tick();
            count++;
            ch0Sample = '{data: sampleW'($urandom), valid: 1'b0};
            ch1Sample = '{data: sampleW'($urandom), valid: 1'b0};
        end
        if (dac1Data !== dacCode(d1)) begin
            $display("Timeout at %0t: dac1Data never took the channel 1 sample", $realtime);
            errors++;
        end else if (count != 2) begin
            reportFail($sformatf("dac1Data updated after %0d cycles, expected 2", count));
        end
        if (dac0Data !== dacCode(d0)) reportFail($sformatf("dac0Data %h, expected %h",
                                                             dac0Data, dacCode(d0)));
        if (dac2Data !== dacCode(d0)) reportFail($sformatf("dac2Data %h on code 5, expected %h",
                                                             dac2Data, dacCode(d0)));
        // Samples without valid must not reach the DACs
        held = '{dac0Data, dac1Data, dac2Data};
        for (int n = 0; n < 4; n++) begin
            ch0Sample = '{data: sampleW'($urandom), valid: 1'b0};
            ch1Sample = '{data: sampleW'($urandom), valid: 1'b0};
            tick();
        end
        if (dac0Data !== held[0] || dac1Data !== held[1] || dac2Data !== held[2]) begin
            reportFail("DAC output changed on samples with valid low");
        end
        closeTest("dac", start);
    endtask

    task automatic adcTest();
        int              start;
        logic [adcW-1:0] prev0;
        logic [adcW-1:0] prev1;
        sampleT          exp0;
        sampleT          exp1;
        start = errors;
        for (int n = 0; n < 10; n++) begin
            adc0 = adcW'($urandom);
            adc1 = adcW'($urandom);
            tick();
            // Word from the previous pass, two edges after it was driven
            exp0 = adcSample(prev0);
            exp1 = adcSample(prev1);
            if (n > 0 && rx0 !== exp0) begin
                reportFail($sformatf("rx0 %h, expected %h", rx0.data, exp0.data));
            end
            if (n > 0 && rx1 !== exp1) begin
                reportFail($sformatf("rx1 %h, expected %h", rx1.data, exp1.data));
            end
            prev0 = adc0;
            prev1 = adc1;
        end
        closeTest("adc", start);
    endtask

    task automatic controlTest();
        int                  start;
        logic [busDataW-1:0] value;
        start = errors;
        for (int n = 0; n < 4; n++) begin
            value = 16'($urandom);
            value[1:0] = 2'(n + 1);
            busWrite(REG_CONTROL, value, 1'b1, 1'b0);
            if (coreEnable !== value[1:0]) begin
                reportFail($sformatf("coreEnable %b, expected %b", coreEnable, value[1:0]));
            end
        end
        closeTest("control", start);
    endtask

    // **********************************************************************
    // Sequence
    // **********************************************************************
    initial begin
        void'($urandom(69));
        $timeformat(-9, 1, " ns", 0);
        errors    = 0;
        testCount = 0;
        rstN      = 1'b0;
        hostReq   = '0;
        adc0      = '0;
        adc1      = '0;
        ch0Sample = '0;
        ch1Sample = '0;
        ch0Sym    = '0;
        ch1Sym    = '0;
        ch0Lock   = 1'b0;
        ch1Lock   = 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        #1;
        rstN = 1'b1;

        resetTest();
        regTest();
        routeTest();
        dacTest();
        adcTest();
        controlTest();

        errors += i_dut.i_props.failCount;
        $display("Tests run %0d, errors %0d", testCount, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bitsyncIoTop.f */
design/bsBusPkg.sv
design/bsRoutePkg.sv
design/hostRegs.sv
design/adcCondition.sv
design/dacDriver.sv
design/outputRouter.sv
design/bitsyncIoTop.sv
verif/bitsyncIoTb_props.sv
verif/bitsyncIoTb.sv

/* Bender.yml */
package:
  name: bitsync_io

sources:
  - design/bsBusPkg.sv
  - design/bsRoutePkg.sv
  - design/hostRegs.sv
  - design/adcCondition.sv
  - design/dacDriver.sv
  - design/outputRouter.sv
  - design/bitsyncIoTop.sv
  - target: test
    files:
      - verif/bitsyncIoTb_props.sv
      - verif/bitsyncIoTb.sv
